// ==== hw/mem_ctrl_macros.svh ====
/*
    memory controller widths
    word, block address, RAM address and queue depths
*/

`ifndef MEM_CTRL_MACROS_SVH
`define MEM_CTRL_MACROS_SVH

// RAM word and block address
`define MEM_WORD_W 32
`define MEM_BLOCK_ADDR_W 13

// byte address at the RAM port
// zero pad, block addr, beat bit, two byte bits
`define MEM_ADDR_W 32

// queue depths, powers of two only
`define MEM_RQ_DEPTH 4
`define MEM_WQ_DEPTH 8

`endif

// ==== hw/mem_ctrl_pkg.sv ====
/*
    memory controller types
    words, blocks, queue entries and controller state
*/

`include "mem_ctrl_macros.svh"

package mem_ctrl_pkg;

    // one RAM word
    typedef logic [`MEM_WORD_W-1:0] word_t;

    // block address, one block = two words
    typedef logic [`MEM_BLOCK_ADDR_W-1:0] block_addr_t;

    // word 0 at block offset 0
    typedef word_t [1:0] block_data_t;

    // read queue entry
    typedef struct packed {
        block_addr_t block_addr;
        // requesting core
        logic core;
    } rd_entry_t;

    // write queue entry
    typedef struct packed {
        block_addr_t block_addr;
        block_data_t data;
    } wr_entry_t;

    // controller FSM
    typedef enum logic [1:0] {
        ARBITRATE,
        ACCESS_0,
        ACCESS_1,
        HALT
    } mc_state_t;

endpackage

// ==== hw/dual_enq_queue_if.sv ====
/*
    dual-enqueue single-dequeue queue bundle
    two enqueue slots per cycle, head view and occupancy
*/

interface dual_enq_queue_if #(
    parameter type entry_t = logic,
    parameter int DEPTH = 4
);

    // enqueue side, slot 0 lands first
    logic enq0_valid;
    entry_t enq0_entry;
    logic enq1_valid;
    entry_t enq1_entry;

    // dequeue side
    logic deq;
    logic head_valid;
    entry_t head_entry;

    // occupancy, 0 to DEPTH
    logic [$clog2(DEPTH):0] count;

    modport queue (
        input enq0_valid, enq0_entry, enq1_valid, enq1_entry, deq,
        output head_valid, head_entry, count
    );

    modport user (
        output deq,
        input head_valid, head_entry, count
    );

endinterface

// ==== hw/dual_enq_queue.sv ====
/*
    circular queue with two enqueue slots per cycle
    head dequeue, occupancy count, storage visible for search
*/

module dual_enq_queue #(
    parameter type entry_t = logic,
    parameter int DEPTH = 4
) (
    input logic CLK,
    input logic nRST,
    dual_enq_queue_if.queue q,
    output entry_t entries [DEPTH],
    output logic [DEPTH-1:0] valids,
    output logic [$clog2(DEPTH)-1:0] head_idx
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int PTR_W = IDX_W + 1;

    // pointers carry a wrap bit above the index
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;

    logic [IDX_W-1:0] tail_idx;
    logic [IDX_W-1:0] enq1_idx;

    assign head_idx = head[IDX_W-1:0];
    assign tail_idx = tail[IDX_W-1:0];

    // slot 1 goes behind slot 0 when both enqueue
    assign enq1_idx = q.enq0_valid ? tail_idx + 1'b1 : tail_idx;

    assign q.count = tail - head;
    assign q.head_valid = valids[head_idx];
    assign q.head_entry = entries[head_idx];

    ////////////////////////////////////////
    // storage

    always_ff @(posedge CLK) begin
        if (q.enq0_valid) begin
            entries[tail_idx] <= q.enq0_entry;
        end
        if (q.enq1_valid) begin
            entries[enq1_idx] <= q.enq1_entry;
        end
    end

    ////////////////////////////////////////
    // pointers and valid bits

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            head <= '0;
            tail <= '0;
            valids <= '0;
        end else begin
            // clear before set, a full queue may refill the head slot
            if (q.deq) begin
                valids[head_idx] <= 1'b0;
                head <= head + 1'b1;
            end
            if (q.enq0_valid) begin
                valids[tail_idx] <= 1'b1;
            end
            if (q.enq1_valid) begin
                valids[enq1_idx] <= 1'b1;
            end
            tail <= tail + PTR_W'(q.enq0_valid) + PTR_W'(q.enq1_valid);
        end
    end

    // requesters must respect capacity
    a_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
        int'(q.count) + int'(q.enq0_valid) + int'(q.enq1_valid) <= DEPTH + int'(q.deq));

    // dequeue only what is there
    a_no_underflow: assert property (@(posedge CLK) disable iff (!nRST)
        q.deq |-> q.count != '0);

endmodule

// ==== hw/write_forward.sv ====
/*
    write queue search
    youngest valid entry matching a block address
*/

`include "mem_ctrl_macros.svh"

module write_forward (
    input mem_ctrl_pkg::wr_entry_t entries [`MEM_WQ_DEPTH],
    input logic [`MEM_WQ_DEPTH-1:0] valids,
    input logic [$clog2(`MEM_WQ_DEPTH)-1:0] head_idx,
    input mem_ctrl_pkg::block_addr_t match_addr,
    output logic found,
    output mem_ctrl_pkg::block_data_t data
);
    import mem_ctrl_pkg::*;

    localparam int IDX_W = $clog2(`MEM_WQ_DEPTH);

    // age = ring distance from head, larger is younger
    always_comb begin
        logic [IDX_W-1:0] age;
        logic [IDX_W-1:0] best_age;

        found = 1'b0;
        data = '0;
        best_age = '0;
        for (int i = 0; i < `MEM_WQ_DEPTH; i++) begin
            age = IDX_W'(i) - head_idx;
            if (valids[i] && entries[i].block_addr == match_addr) begin
                // first hit, or younger than the best so far
                if (!found || age >= best_age) begin
                    found = 1'b1;
                    best_age = age;
                    data = entries[i].data;
                end
            end
        end
    end

endmodule

// ==== hw/mem_access_fsm.sv ====
/*
    memory controller FSM
    arbitration, two-beat RAM sequencing, imem fairness,
    read response steering and flush halt
*/

`include "mem_ctrl_macros.svh"

module mem_access_fsm (
    input logic CLK,
    input logic nRST,
    dual_enq_queue_if.user rd_q,
    dual_enq_queue_if.user wr_q,
    input logic imem0_ren,
    input mem_ctrl_pkg::block_addr_t imem0_block_addr,
    input logic imem1_ren,
    input mem_ctrl_pkg::block_addr_t imem1_block_addr,
    output logic imem0_hit,
    output logic imem1_hit,
    output mem_ctrl_pkg::block_data_t imem_load,
    input logic fwd_found,
    input mem_ctrl_pkg::block_data_t fwd_data,
    output mem_ctrl_pkg::block_addr_t work_addr,
    output logic dmem0_read_resp_valid,
    output logic dmem1_read_resp_valid,
    output mem_ctrl_pkg::block_data_t dmem_read_resp_data,
    input logic dcache0_flushed,
    input logic dcache1_flushed,
    output logic mem_controller_flushed,
    output logic ram_ren,
    output logic ram_wen,
    output logic [`MEM_ADDR_W-1:0] ram_addr,
    output mem_ctrl_pkg::word_t ram_store,
    input mem_ctrl_pkg::word_t ram_load,
    input logic ram_access
);
    import mem_ctrl_pkg::*;

    // zero field above the block address
    localparam int PAD_W = `MEM_ADDR_W - `MEM_BLOCK_ADDR_W - 3;

    mc_state_t state;

    // 1 = imem1 goes next on a tie
    logic imem_fair;

    // working request, kind bits
    logic wk_imem0;
    logic wk_imem1;
    logic wk_dmem0;
    logic wk_dmem1;
    logic wk_write;

    // working request, payload
    block_addr_t wk_addr;
    block_data_t wk_wdata;
    word_t wk_word0;

    logic halt_go;
    logic rd_sel;
    logic wr_sel;
    logic imem_sel;
    logic take_imem0;
    logic take_imem1;
    logic start;
    logic beat;
    logic dmem_end;
    block_addr_t sel_addr;

    ////////////////////////////////////////
    // arbitration

    // halt needs both caches clean and no writes left
    assign halt_go = dcache0_flushed && dcache1_flushed && wr_q.count == '0;

    // data read, then data write, then imem
    assign rd_sel = state == ARBITRATE && !halt_go && rd_q.head_valid;
    assign wr_sel = state == ARBITRATE && !halt_go && !rd_q.head_valid && wr_q.head_valid;
    assign imem_sel = state == ARBITRATE && !halt_go && !rd_q.head_valid
        && !wr_q.head_valid && (imem0_ren || imem1_ren);

    // imem1 wins alone or on a tie with the fairness bit set
    assign take_imem1 = imem_sel && imem1_ren && (!imem0_ren || imem_fair);
    assign take_imem0 = imem_sel && !take_imem1;
    assign start = rd_sel || wr_sel || imem_sel;

    assign rd_q.deq = rd_sel;
    assign wr_q.deq = wr_sel;

    always_comb begin
        if (rd_sel) begin
            sel_addr = rd_q.head_entry.block_addr;
        end else if (wr_sel) begin
            sel_addr = wr_q.head_entry.block_addr;
        end else if (take_imem1) begin
            sel_addr = imem1_block_addr;
        end else begin
            sel_addr = imem0_block_addr;
        end
    end

    ////////////////////////////////////////
    // RAM port

    assign beat = state == ACCESS_1;
    assign ram_ren = (state == ACCESS_0 || beat) && !wk_write;
    assign ram_wen = (state == ACCESS_0 || beat) && wk_write;
    assign ram_addr = {{PAD_W{1'b0}}, wk_addr, beat, 2'b00};
    assign ram_store = beat ? wk_wdata[1] : wk_wdata[0];
    assign work_addr = wk_addr;

    // data read done on beat 1 or early on a forward hit
    assign dmem_end = beat && (wk_dmem0 || wk_dmem1) && (ram_access || fwd_found);

    // imem hit only if the port still wants this block
    assign imem_load = {ram_load, wk_word0};
    assign imem0_hit = beat && ram_access && wk_imem0 && imem0_ren
        && imem0_block_addr == wk_addr;
    assign imem1_hit = beat && ram_access && wk_imem1 && imem1_ren
        && imem1_block_addr == wk_addr;

    ////////////////////////////////////////
    // state and control

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= ARBITRATE;
            imem_fair <= 1'b0;
            wk_imem0 <= 1'b0;
            wk_imem1 <= 1'b0;
            wk_dmem0 <= 1'b0;
            wk_dmem1 <= 1'b0;
            wk_write <= 1'b0;
            dmem0_read_resp_valid <= 1'b0;
            dmem1_read_resp_valid <= 1'b0;
            mem_controller_flushed <= 1'b0;
        end else begin
            // response goes back to the core that asked
            dmem0_read_resp_valid <= dmem_end && wk_dmem0;
            dmem1_read_resp_valid <= dmem_end && wk_dmem1;
            mem_controller_flushed <= state == HALT;
            if (start) begin
                wk_imem0 <= take_imem0;
                wk_imem1 <= take_imem1;
                wk_dmem0 <= rd_sel && !rd_q.head_entry.core;
                wk_dmem1 <= rd_sel && rd_q.head_entry.core;
                wk_write <= wr_sel;
            end
            // point at the port not served, toggles on a tie
            if (imem_sel) begin
                imem_fair <= take_imem0;
            end
            case (state)
                ARBITRATE: begin
                    if (halt_go) begin
                        state <= HALT;
                    end else if (start) begin
                        state <= ACCESS_0;
                    end
                end
                ACCESS_0: begin
                    if (ram_access) begin
                        state <= ACCESS_1;
                    end
                end
                ACCESS_1: begin
                    if (ram_access || dmem_end) begin
                        state <= ARBITRATE;
                    end
                end
                default: begin
                    state <= HALT;
                end
            endcase
        end
    end

    // payload, no reset
    always_ff @(posedge CLK) begin
        if (start) begin
            wk_addr <= sel_addr;
            wk_wdata <= wr_q.head_entry.data;
        end
        if (state == ACCESS_0 && ram_access) begin
            wk_word0 <= ram_load;
        end
        // forwarded data beats RAM, the write is not in RAM yet
        if (dmem_end) begin
            dmem_read_resp_data <= fwd_found ? fwd_data : {ram_load, wk_word0};
        end
    end

    // one kind of work at a time
    a_one_kind: assert property (@(posedge CLK) disable iff (!nRST)
        $onehot0({wk_imem0, wk_imem1, wk_dmem0, wk_dmem1, wk_write}));

endmodule

// ==== hw/dual_mem_controller.sv ====
/*
    dual-core memory controller
    two imem ports, shared data read and write queues,
    one two-word block at a time against a word RAM
*/

`include "mem_ctrl_macros.svh"

module dual_mem_controller (
    input logic CLK,
    input logic nRST,

    // imem ports
    input logic imem0_ren,
    input mem_ctrl_pkg::block_addr_t imem0_block_addr,
    output logic imem0_hit,
    output mem_ctrl_pkg::block_data_t imem0_load,
    input logic imem1_ren,
    input mem_ctrl_pkg::block_addr_t imem1_block_addr,
    output logic imem1_hit,
    output mem_ctrl_pkg::block_data_t imem1_load,

    // dmem read requests and responses
    input logic dmem0_read_req_valid,
    input mem_ctrl_pkg::block_addr_t dmem0_read_req_block_addr,
    input logic dmem1_read_req_valid,
    input mem_ctrl_pkg::block_addr_t dmem1_read_req_block_addr,
    output logic dmem0_read_resp_valid,
    output mem_ctrl_pkg::block_data_t dmem0_read_resp_data,
    output logic dmem1_read_resp_valid,
    output mem_ctrl_pkg::block_data_t dmem1_read_resp_data,

    // dmem write requests
    input logic dmem0_write_req_valid,
    input mem_ctrl_pkg::block_addr_t dmem0_write_req_block_addr,
    input mem_ctrl_pkg::block_data_t dmem0_write_req_data,
    output logic dmem0_write_req_slow_down,
    input logic dmem1_write_req_valid,
    input mem_ctrl_pkg::block_addr_t dmem1_write_req_block_addr,
    input mem_ctrl_pkg::block_data_t dmem1_write_req_data,
    output logic dmem1_write_req_slow_down,

    // flush
    input logic dcache0_flushed,
    input logic dcache1_flushed,
    output logic mem_controller_flushed,

    // RAM port
    output logic ram_ren,
    output logic ram_wen,
    output logic [`MEM_ADDR_W-1:0] ram_addr,
    output mem_ctrl_pkg::word_t ram_store,
    input mem_ctrl_pkg::word_t ram_load,
    input logic ram_access
);
    import mem_ctrl_pkg::*;

    dual_enq_queue_if #(.entry_t(rd_entry_t), .DEPTH(`MEM_RQ_DEPTH)) rd_q ();
    dual_enq_queue_if #(.entry_t(wr_entry_t), .DEPTH(`MEM_WQ_DEPTH)) wr_q ();

    // write queue storage for forwarding
    wr_entry_t wr_entries [`MEM_WQ_DEPTH];
    logic [`MEM_WQ_DEPTH-1:0] wr_valids;
    logic [$clog2(`MEM_WQ_DEPTH)-1:0] wr_head_idx;

    logic fwd_found;
    block_data_t fwd_data;
    block_addr_t work_addr;
    block_data_t imem_load;
    block_data_t dmem_read_resp_data;

    ////////////////////////////////////////
    // queue enqueue, core 0 in slot 0

    assign rd_q.enq0_valid = dmem0_read_req_valid;
    assign rd_q.enq0_entry = '{block_addr: dmem0_read_req_block_addr, core: 1'b0};
    assign rd_q.enq1_valid = dmem1_read_req_valid;
    assign rd_q.enq1_entry = '{block_addr: dmem1_read_req_block_addr, core: 1'b1};

    assign wr_q.enq0_valid = dmem0_write_req_valid;
    assign wr_q.enq0_entry = '{block_addr: dmem0_write_req_block_addr,
                               data: dmem0_write_req_data};
    assign wr_q.enq1_valid = dmem1_write_req_valid;
    assign wr_q.enq1_entry = '{block_addr: dmem1_write_req_block_addr,
                               data: dmem1_write_req_data};

    // slow down above half full
    assign dmem0_write_req_slow_down = wr_q.count > (`MEM_WQ_DEPTH / 2);
    assign dmem1_write_req_slow_down = wr_q.count > (`MEM_WQ_DEPTH / 2);

    // shared return buses
    assign imem0_load = imem_load;
    assign imem1_load = imem_load;
    assign dmem0_read_resp_data = dmem_read_resp_data;
    assign dmem1_read_resp_data = dmem_read_resp_data;

    ////////////////////////////////////////
    // instances

    // read queue storage is not searched
    dual_enq_queue #(.entry_t(rd_entry_t), .DEPTH(`MEM_RQ_DEPTH)) rd_q_i (
        .CLK(CLK),
        .nRST(nRST),
        .q(rd_q),
        .entries(),
        .valids(),
        .head_idx()
    );

    dual_enq_queue #(.entry_t(wr_entry_t), .DEPTH(`MEM_WQ_DEPTH)) wr_q_i (
        .CLK(CLK),
        .nRST(nRST),
        .q(wr_q),
        .entries(wr_entries),
        .valids(wr_valids),
        .head_idx(wr_head_idx)
    );

    write_forward fwd_i (
        .entries(wr_entries),
        .valids(wr_valids),
        .head_idx(wr_head_idx),
        .match_addr(work_addr),
        .found(fwd_found),
        .data(fwd_data)
    );

    mem_access_fsm fsm_i (
        .CLK(CLK),
        .nRST(nRST),
        .rd_q(rd_q),
        .wr_q(wr_q),
        .imem0_ren(imem0_ren),
        .imem0_block_addr(imem0_block_addr),
        .imem1_ren(imem1_ren),
        .imem1_block_addr(imem1_block_addr),
        .imem0_hit(imem0_hit),
        .imem1_hit(imem1_hit),
        .imem_load(imem_load),
        .fwd_found(fwd_found),
        .fwd_data(fwd_data),
        .work_addr(work_addr),
        .dmem0_read_resp_valid(dmem0_read_resp_valid),
        .dmem1_read_resp_valid(dmem1_read_resp_valid),
        .dmem_read_resp_data(dmem_read_resp_data),
        .dcache0_flushed(dcache0_flushed),
        .dcache1_flushed(dcache1_flushed),
        .mem_controller_flushed(mem_controller_flushed),
        .ram_ren(ram_ren),
        .ram_wen(ram_wen),
        .ram_addr(ram_addr),
        .ram_store(ram_store),
        .ram_load(ram_load),
        .ram_access(ram_access)
    );

endmodule

// ==== tests/ram_model.sv ====
/*
    behavioral word RAM for the memory controller testbench
    random wait of 0 to 3 cycles before each access completes
*/

`include "mem_ctrl_macros.svh"

module ram_model (
    input logic CLK,
    input logic nRST,
    input logic ren,
    input logic wen,
    input logic [`MEM_ADDR_W-1:0] addr,
    input mem_ctrl_pkg::word_t store,
    output mem_ctrl_pkg::word_t load,
    output logic access
);
    import mem_ctrl_pkg::*;

    // word index = block address plus beat bit
    localparam int IDX_W = `MEM_BLOCK_ADDR_W + 1;

    word_t mem [2**IDX_W];
    logic [IDX_W-1:0] idx;
    logic [1:0] wait_cnt;

    // same fill as the testbench reference memory
    function automatic word_t fill_word(input int widx);
        return (word_t'(widx) * 32'h0001_0003) ^ 32'hA5A5_0000;
    endfunction

    initial begin
        for (int i = 0; i < 2**IDX_W; i++) begin
            mem[i] = fill_word(i);
        end
    end

    // byte bits dropped, pad bits ignored
    assign idx = addr[IDX_W+1:2];
    assign load = mem[idx];
    assign access = (ren || wen) && wait_cnt == 2'd0;

    always @(posedge CLK) begin
        if (wen && access) begin
            mem[idx] <= store;
        end
    end

    // new wait drawn after every completed beat
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= 2'd0;
        end else if (access) begin
            wait_cnt <= 2'($urandom % 4);
        end else if ((ren || wen) && wait_cnt != 2'd0) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

endmodule

// ==== tests/tb_dual_mem_controller.sv ====
/*
    testbench for the dual-core memory controller
    table of operations checked against a reference block memory
*/

`include "mem_ctrl_macros.svh"

module tb_dual_mem_controller;
    import mem_ctrl_pkg::*;

    typedef enum logic [2:0] {
        OP_IMEM, OP_WRITE, OP_READ, OP_DUAL_READ, OP_BURST, OP_FAIR, OP_FLUSH
    } op_kind_t;

    // expected block per core
    typedef struct packed {
        op_kind_t kind;
        logic core;
        block_addr_t addr;
        block_data_t data;
        block_data_t [1:0] exp;
    } op_t;

    logic CLK = 1'b0;
    logic nRST;
    logic [1:0] imem_ren;
    block_addr_t imem_addr [2];
    logic [1:0] imem_hit;
    block_data_t imem_load [2];
    logic [1:0] rd_valid;
    block_addr_t rd_addr [2];
    logic [1:0] rd_resp_valid;
    block_data_t rd_resp_data [2];
    logic [1:0] wr_valid;
    block_addr_t wr_addr [2];
    block_data_t wr_data [2];
    logic [1:0] slow_down;
    logic [1:0] dcache_flushed;
    logic flushed;
    logic ram_ren;
    logic ram_wen;
    logic [`MEM_ADDR_W-1:0] ram_addr;
    word_t ram_store;
    word_t ram_load;
    logic ram_access;

    block_data_t ref_mem [2**`MEM_BLOCK_ADDR_W];
    op_t ops [$];
    int op_num;
    int errors = 0;
    int slow_cycles = 0;
    logic table_ready = 1'b0;

    always #4 CLK = ~CLK;

    dual_mem_controller dut_i (
        .CLK(CLK), .nRST(nRST),
        .imem0_ren(imem_ren[0]), .imem0_block_addr(imem_addr[0]),
        .imem0_hit(imem_hit[0]), .imem0_load(imem_load[0]),
        .imem1_ren(imem_ren[1]), .imem1_block_addr(imem_addr[1]),
        .imem1_hit(imem_hit[1]), .imem1_load(imem_load[1]),
        .dmem0_read_req_valid(rd_valid[0]), .dmem0_read_req_block_addr(rd_addr[0]),
        .dmem1_read_req_valid(rd_valid[1]), .dmem1_read_req_block_addr(rd_addr[1]),
        .dmem0_read_resp_valid(rd_resp_valid[0]), .dmem0_read_resp_data(rd_resp_data[0]),
        .dmem1_read_resp_valid(rd_resp_valid[1]), .dmem1_read_resp_data(rd_resp_data[1]),
        .dmem0_write_req_valid(wr_valid[0]), .dmem0_write_req_block_addr(wr_addr[0]),
        .dmem0_write_req_data(wr_data[0]), .dmem0_write_req_slow_down(slow_down[0]),
        .dmem1_write_req_valid(wr_valid[1]), .dmem1_write_req_block_addr(wr_addr[1]),
        .dmem1_write_req_data(wr_data[1]), .dmem1_write_req_slow_down(slow_down[1]),
        .dcache0_flushed(dcache_flushed[0]), .dcache1_flushed(dcache_flushed[1]),
        .mem_controller_flushed(flushed),
        .ram_ren(ram_ren), .ram_wen(ram_wen), .ram_addr(ram_addr),
        .ram_store(ram_store), .ram_load(ram_load), .ram_access(ram_access)
    );

    ram_model ram_i (
        .CLK(CLK), .nRST(nRST), .ren(ram_ren), .wen(ram_wen), .addr(ram_addr),
        .store(ram_store), .load(ram_load), .access(ram_access)
    );

    // cycles with both slow-down outputs up
    always @(negedge CLK) begin
        if (slow_down == 2'b11) begin
            slow_cycles <= slow_cycles + 1;
        end
    end

    ////////////////////////////////////////
    // reporting

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "first error, run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            stop_run($sformatf("mismatch %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    function automatic string label(input string what);
        return $sformatf("op %0d %s", op_num, what);
    endfunction

    initial begin
        wait (table_ready);
        repeat (ops.size() * 40 + 8) @(posedge CLK);
        stop_run($sformatf("timeout, tests not done within %0d cycles", ops.size() * 40));
    end

    ////////////////////////////////////////
    // reference memory and table

    function automatic word_t fill_word(input int widx);
        return (word_t'(widx) * 32'h0001_0003) ^ 32'hA5A5_0000;
    endfunction

    // write i of a burst, base data plus i
    function automatic block_data_t burst_data(input block_data_t base, input int i);
        block_data_t r;
        r[0] = base[0] + word_t'(i);
        r[1] = base[1] + word_t'(i);
        return r;
    endfunction

    // expected values follow the reference in table order
    task automatic add_op(input op_kind_t kind, input logic core, input block_addr_t addr,
                          input block_data_t data);
        op_t op;
        op.kind = kind;
        op.core = core;
        op.addr = addr;
        op.data = data;
        op.exp = '0;
        case (kind)
            OP_IMEM, OP_READ: begin
                op.exp[core] = ref_mem[addr];
            end
            OP_WRITE: begin
                ref_mem[addr] = data;
            end
            OP_DUAL_READ, OP_FAIR: begin
                op.exp[0] = ref_mem[addr];
                op.exp[1] = ref_mem[addr + 13'd1];
            end
            OP_BURST: begin
                op.exp[core] = ref_mem[addr];
                for (int i = 0; i < 5; i++) begin
                    ref_mem[addr + 13'(i + 1)] = burst_data(data, i);
                end
            end
            default: begin
            end
        endcase
        ops.push_back(op);
    endtask

    task automatic build_table();
        for (int b = 0; b < 2**`MEM_BLOCK_ADDR_W; b++) begin
            ref_mem[b] = {fill_word(2 * b + 1), fill_word(2 * b)};
        end
        add_op(OP_IMEM, 1'b0, 13'h010, '0);
        add_op(OP_IMEM, 1'b1, 13'h011, '0);
        add_op(OP_READ, 1'b0, 13'h020, '0);
        add_op(OP_WRITE, 1'b0, 13'h030, {32'h1111_0001, 32'h1111_0000});
        add_op(OP_READ, 1'b1, 13'h030, '0);
        // two writes to one block behind a busy machine, youngest wins
        add_op(OP_WRITE, 1'b1, 13'h040, {32'h2222_0001, 32'h2222_0000});
        add_op(OP_WRITE, 1'b0, 13'h041, {32'h3333_0001, 32'h3333_0000});
        add_op(OP_WRITE, 1'b1, 13'h041, {32'h4444_0001, 32'h4444_0000});
        add_op(OP_READ, 1'b0, 13'h041, '0);
        add_op(OP_DUAL_READ, 1'b0, 13'h050, '0);
        add_op(OP_BURST, 1'b1, 13'h060, {32'hB000_0100, 32'hB000_0000});
        add_op(OP_READ, 1'b0, 13'h063, '0);
        add_op(OP_FAIR, 1'b0, 13'h070, '0);
        add_op(OP_IMEM, 1'b0, 13'h030, '0);
        add_op(OP_FLUSH, 1'b0, 13'h000, '0);
    endtask

    ////////////////////////////////////////
    // stimulus helpers

    task automatic drive_point();
        @(posedge CLK);
        #1;
    endtask

    // no RAM activity for four cycles, queues empty
    task automatic wait_idle();
        int quiet;
        quiet = 0;
        while (quiet < 4) begin
            @(negedge CLK);
            if (ram_ren || ram_wen) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    task automatic wait_read_resp(input int core);
        @(negedge CLK);
        while (!rd_resp_valid[core]) begin
            if (rd_resp_valid[core ^ 1]) begin
                stop_run($sformatf("response valid of core %0d rose while core %0d waited",
                                   core ^ 1, core));
            end
            @(negedge CLK);
        end
    endtask

    task automatic put_write(input int core, input int i, input op_t op);
        wr_valid[core] = 1'b1;
        wr_addr[core] = op.addr + 13'(i + 1);
        wr_data[core] = burst_data(op.data, i);
    endtask

    ////////////////////////////////////////
    // operations

    task automatic run_op(input op_t op);
        int c;
        int base;
        int hits [2];
        c = int'(op.core);
        case (op.kind)
            OP_IMEM: begin
                drive_point();
                imem_ren[c] = 1'b1;
                imem_addr[c] = op.addr;
                @(negedge CLK);
                while (!imem_hit[c]) @(negedge CLK);
                check_value(label("imem load"), op.exp[c], imem_load[c]);
                drive_point();
                imem_ren[c] = 1'b0;
            end
            OP_WRITE: begin
                drive_point();
                wr_valid[c] = 1'b1;
                wr_addr[c] = op.addr;
                wr_data[c] = op.data;
                drive_point();
                wr_valid[c] = 1'b0;
            end
            OP_READ: begin
                drive_point();
                rd_valid[c] = 1'b1;
                rd_addr[c] = op.addr;
                drive_point();
                rd_valid[c] = 1'b0;
                wait_read_resp(c);
                check_value(label("read data"), op.exp[c], rd_resp_data[c]);
            end
            OP_DUAL_READ: begin
                drive_point();
                rd_valid = 2'b11;
                rd_addr[0] = op.addr;
                rd_addr[1] = op.addr + 13'd1;
                drive_point();
                rd_valid = 2'b00;
                // core 0 sits in slot 0, answered first
                wait_read_resp(0);
                check_value(label("core 0 data"), op.exp[0], rd_resp_data[0]);
                wait_read_resp(1);
                check_value(label("core 1 data"), op.exp[1], rd_resp_data[1]);
            end
            OP_BURST: begin
                wait_idle();
                base = slow_cycles;
                // read first, it holds the machine while writes pile up
                drive_point();
                rd_valid[c] = 1'b1;
                rd_addr[c] = op.addr;
                put_write(0, 0, op);
                put_write(1, 1, op);
                drive_point();
                rd_valid[c] = 1'b0;
                put_write(0, 2, op);
                put_write(1, 3, op);
                drive_point();
                put_write(0, 4, op);
                wr_valid[1] = 1'b0;
                drive_point();
                wr_valid = 2'b00;
                wait_read_resp(c);
                check_value(label("stalling read"), op.exp[c], rd_resp_data[c]);
                check_value(label("slow-down raised"), 64'd1, 64'(slow_cycles > base));
                wait_idle();
                check_value(label("slow-down after drain"), 64'd0, 64'(slow_down));
            end
            OP_FAIR: begin
                hits[0] = 0;
                hits[1] = 0;
                drive_point();
                imem_ren = 2'b11;
                imem_addr[0] = op.addr;
                imem_addr[1] = op.addr + 13'd1;
                while (hits[0] < 2 || hits[1] < 2) begin
                    @(negedge CLK);
                    for (int p = 0; p < 2; p++) begin
                        if (imem_hit[p]) begin
                            check_value(label("fair load"), op.exp[p], imem_load[p]);
                            check_value(label("fair turn"), 64'd1,
                                        64'(hits[p] <= hits[p ^ 1]));
                            hits[p]++;
                        end
                    end
                end
                drive_point();
                imem_ren = 2'b00;
            end
            OP_FLUSH: begin
                wait_idle();
                drive_point();
                dcache_flushed = 2'b11;
                @(negedge CLK);
                while (!flushed) @(negedge CLK);
                // halt is final
                repeat (4) begin
                    @(negedge CLK);
                    check_value(label("flushed held"), 64'd1, 64'(flushed));
                end
            end
            default: begin
                stop_run("unknown operation kind in the table");
            end
        endcase
    endtask

    ////////////////////////////////////////
    // main sequence

    initial begin
        void'($urandom(36832));
        nRST = 1'b0;
        imem_ren = 2'b00;
        imem_addr = '{default: '0};
        rd_valid = 2'b00;
        rd_addr = '{default: '0};
        wr_valid = 2'b00;
        wr_addr = '{default: '0};
        wr_data = '{default: '0};
        dcache_flushed = 2'b00;
        build_table();
        table_ready = 1'b1;
        repeat (4) @(posedge CLK);
        #1;
        check_value("reset outputs", 64'd0, 64'({ram_ren, ram_wen, imem_hit, rd_resp_valid,
                                                   slow_down, flushed}));
        nRST = 1'b1;
        for (int n = 0; n < ops.size(); n++) begin
            op_num = n;
            run_op(ops[n]);
        end
        if (errors == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "run ended with failed checks");
        end
    end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/mem_ctrl_pkg.sv
hw/dual_enq_queue_if.sv
hw/dual_enq_queue.sv
hw/write_forward.sv
hw/mem_access_fsm.sv
hw/dual_mem_controller.sv
tests/ram_model.sv
tests/tb_dual_mem_controller.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the memory controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timing \
    --top-module tb_dual_mem_controller \
    -f filelist.f \
    -o sim_tb

# a failing run still leaves its log for the search below
./obj_dir/sim_tb > sim.log 2>&1 || true

if grep -qx "Finished with no errors" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
